// ==== hw/cpuPkg.sv ====
package cpuPkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Memory sizes in 32-bit words
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_DEPTH);
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000; // Also SUB with inst[30]
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5, // Signed compare
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } aluOpT;

endpackage

// ==== hw/alu.sv ====
module alu (
    input  logic [cpuPkg::XLEN-1:0] a,
    input  logic [cpuPkg::XLEN-1:0] b,
    input  cpuPkg::aluOpT          op,
    output logic [cpuPkg::XLEN-1:0] result,
    output logic                   zero
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = b[4:0]; // Upper bits ignored
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpuPkg::ALU_ADD: result = a + b;
            cpuPkg::ALU_SUB: result = a - b;
            cpuPkg::ALU_AND: result = a & b;
            cpuPkg::ALU_OR:  result = a | b;
            cpuPkg::ALU_XOR: result = a ^ b;
            cpuPkg::ALU_SLT: result = {{(cpuPkg::XLEN-1){1'b0}}, lessThan};
            cpuPkg::ALU_SLL: result = a << shamt;
            cpuPkg::ALU_SRL: result = a >> shamt; // Logical, zero fill
            default:         result = '0;
        endcase
    end

    // Used by BEQ/BNE after SUB
    assign zero = (result == '0);

endmodule

// ==== hw/decoder.sv ====
module decoder (
    input  logic [cpuPkg::XLEN-1:0]        inst,
    output logic [cpuPkg::REG_ADDR_W-1:0]  rs1,
    output logic [cpuPkg::REG_ADDR_W-1:0]  rs2,
    output logic [cpuPkg::REG_ADDR_W-1:0]  rd,
    output logic [cpuPkg::XLEN-1:0]        imm,
    output cpuPkg::aluOpT                 aluOp,
    output logic                          aluSrc,
    output logic                          regWrite,
    output logic                          memWrite,
    output logic                          memToReg,
    output logic                          branch,
    output logic                          branchNe
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [cpuPkg::XLEN-1:0] immI;
    logic [cpuPkg::XLEN-1:0] immS;
    logic [cpuPkg::XLEN-1:0] immB;

    // Fixed field positions
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        aluOp    = cpuPkg::ALU_ADD; // Address add for LW/SW
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        imm      = immI;

        case (opcode)
            cpuPkg::OP_RTYPE, cpuPkg::OP_ITYPE: begin
                regWrite = 1'b1;
                aluSrc   = (opcode == cpuPkg::OP_ITYPE);
                case (funct3)
                    // inst[30] selects SUB only for register form
                    cpuPkg::F3_ADD: aluOp = (opcode == cpuPkg::OP_RTYPE && inst[30]) ?
                                            cpuPkg::ALU_SUB : cpuPkg::ALU_ADD;
                    cpuPkg::F3_SLL: aluOp = cpuPkg::ALU_SLL;
                    cpuPkg::F3_SLT: aluOp = cpuPkg::ALU_SLT;
                    cpuPkg::F3_XOR: aluOp = cpuPkg::ALU_XOR;
                    cpuPkg::F3_SRL: aluOp = cpuPkg::ALU_SRL;
                    cpuPkg::F3_OR:  aluOp = cpuPkg::ALU_OR;
                    cpuPkg::F3_AND: aluOp = cpuPkg::ALU_AND;
                    default:        aluOp = cpuPkg::ALU_ADD;
                endcase
            end
            cpuPkg::OP_LOAD: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            cpuPkg::OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                imm      = immS;
            end
            cpuPkg::OP_BRANCH: begin
                aluOp    = cpuPkg::ALU_SUB; // Compare via zero flag
                imm      = immB;
                branch   = (funct3 == cpuPkg::F3_BEQ) || (funct3 == cpuPkg::F3_BNE);
                branchNe = (funct3 == cpuPkg::F3_BNE);
            end
            default: ; // Unsupported opcode runs as a no-op
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
module regFile (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic [cpuPkg::REG_ADDR_W-1:0]  rs1,
    input  logic [cpuPkg::REG_ADDR_W-1:0]  rs2,
    input  logic [cpuPkg::REG_ADDR_W-1:0]  rd,
    input  logic [cpuPkg::XLEN-1:0]        wd,
    input  logic                          we,
    output logic [cpuPkg::XLEN-1:0]        rd1,
    output logic [cpuPkg::XLEN-1:0]        rd2
);

    localparam int NUM_REGS = 2 ** cpuPkg::REG_ADDR_W;

    logic [cpuPkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd; // x0 stays zero
        end
    end

    // No write bypass; the new value shows up next cycle
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/dataMem.sv ====
module dataMem (
    input  logic                          CLK,
    input  logic                          we,
    input  logic [cpuPkg::DMEM_ADDR_W-1:0] addr,
    input  logic [cpuPkg::XLEN-1:0]        wdata,
    output logic [cpuPkg::XLEN-1:0]        rdata
);

    logic [cpuPkg::XLEN-1:0] mem [cpuPkg::DMEM_DEPTH];

    // SW lands at the end of the cycle
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // LW data available in the same cycle
    assign rdata = mem[addr];

endmodule

// ==== hw/instMem.sv ====
module instMem (
    input  logic                          CLK,
    input  logic                          we,
    input  logic [cpuPkg::IMEM_ADDR_W-1:0] waddr,
    input  logic [cpuPkg::XLEN-1:0]        wdata,
    input  logic [cpuPkg::IMEM_ADDR_W-1:0] raddr,
    output logic [cpuPkg::XLEN-1:0]        rdata
);

    // Program storage, kept across reset
    logic [cpuPkg::XLEN-1:0] mem [cpuPkg::IMEM_DEPTH];

    // Load port
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // Fetch is combinational

endmodule

// ==== hw/singleCpu.sv ====
module singleCpu (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          imemWe,
    input  logic [cpuPkg::IMEM_ADDR_W-1:0] imemAddr,
    input  logic [cpuPkg::XLEN-1:0]        imemWdata,
    output logic [cpuPkg::XLEN-1:0]        pc,
    output logic [cpuPkg::XLEN-1:0]        inst,
    output logic                          wbEn,
    output logic [cpuPkg::REG_ADDR_W-1:0]  wbReg,
    output logic [cpuPkg::XLEN-1:0]        wbData
);

    logic [cpuPkg::XLEN-1:0]       pcPlus4;
    logic [cpuPkg::XLEN-1:0]       pcBranch;
    logic [cpuPkg::XLEN-1:0]       pcNext;
    logic [cpuPkg::REG_ADDR_W-1:0] rs1;
    logic [cpuPkg::REG_ADDR_W-1:0] rs2;
    logic [cpuPkg::REG_ADDR_W-1:0] rd;
    logic [cpuPkg::XLEN-1:0]       imm;
    cpuPkg::aluOpT                 aluOp;
    logic                          aluSrc;
    logic                          regWrite;
    logic                          memWrite;
    logic                          memToReg;
    logic                          branch;
    logic                          branchNe;
    logic [cpuPkg::XLEN-1:0]       rd1;
    logic [cpuPkg::XLEN-1:0]       rd2;
    logic [cpuPkg::XLEN-1:0]       aluB;
    logic [cpuPkg::XLEN-1:0]       result;
    logic                          zero;
    logic [cpuPkg::XLEN-1:0]       rdata;
    logic                          takeBranch;
    logic                          dmemWe;

    // Program counter
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcBranch = pc + imm; // imm already shifted for B form

    // BEQ takes on zero, BNE on nonzero
    assign takeBranch = branch & (zero != branchNe);
    assign pcNext     = takeBranch ? pcBranch : pcPlus4;

    instMem instMem_inst (
        .CLK   (CLK),
        .we    (imemWe),
        .waddr (imemAddr),
        .wdata (imemWdata),
        .raddr (pc[cpuPkg::IMEM_ADDR_W+1:2]),
        .rdata (inst)
    );

    decoder decoder_inst (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .branch   (branch),
        .branchNe (branchNe)
    );

    // No commit while in reset, and never to x0
    assign wbEn   = regWrite & ~rst & (rd != '0);
    assign wbReg  = rd;
    assign wbData = memToReg ? rdata : result;

    regFile regFile_inst (
        .CLK (CLK),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd  (rd),
        .wd  (wbData),
        .we  (wbEn),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign aluB = aluSrc ? imm : rd2;

    alu alu_inst (
        .a      (rd1),
        .b      (aluB),
        .op     (aluOp),
        .result (result),
        .zero   (zero)
    );

    // Stores held off while the program is being loaded
    assign dmemWe = memWrite & ~rst;

    dataMem dataMem_inst (
        .CLK   (CLK),
        .we    (dmemWe),
        .addr  (result[cpuPkg::DMEM_ADDR_W+1:2]),
        .wdata (rd2),
        .rdata (rdata)
    );

endmodule

// ==== sim/tbSingleCpu.sv ====
module tbSingleCpu;

    logic                           CLK;
    logic                           rst;
    logic                           imemWe;
    logic [cpuPkg::IMEM_ADDR_W-1:0] imemAddr;
    logic [cpuPkg::XLEN-1:0]        imemWdata;
    logic [cpuPkg::XLEN-1:0]        pc;
    logic [cpuPkg::XLEN-1:0]        inst;
    logic                           wbEn;
    logic [cpuPkg::REG_ADDR_W-1:0]  wbReg;
    logic [cpuPkg::XLEN-1:0]        wbData;

    // Program image and reference model state
    logic [31:0] progMem [cpuPkg::IMEM_DEPTH];
    logic [31:0] mReg [32];
    logic [31:0] mMem [cpuPkg::DMEM_DEPTH];
    logic [31:0] mPc;
    int          runIdx;
    int          cycleCount;
    int          progLen = cpuPkg::IMEM_DEPTH - 8; // Rest is the no-op tail

    // I-type draws from the first five, R-type from all eight; entry 7 becomes SUB
    logic [2:0] aluF3 [8] = '{cpuPkg::F3_ADD, cpuPkg::F3_AND, cpuPkg::F3_OR, cpuPkg::F3_XOR,
                              cpuPkg::F3_SLT, cpuPkg::F3_SLL, cpuPkg::F3_SRL, cpuPkg::F3_ADD};

    singleCpu singleCpu_inst (
        .CLK       (CLK),
        .rst       (rst),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .pc        (pc),
        .inst      (inst),
        .wbEn      (wbEn),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    always #20 CLK = ~CLK;

    task automatic compareValue(string field, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: run%0d cycle%0d %s expected %h actual %h",
                     runIdx, cycleCount, field, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic genProgram();
        int          kind;
        int          i;
        int          span;
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [11:0] imm;
        logic [12:0] bOff;
        // ADDI x1..x4 with random constants, then SW of each to words 0..3
        for (int n = 0; n < 4; n++) begin
            imm            = 12'($urandom);
            progMem[n]     = {imm, 5'd0, cpuPkg::F3_ADD, 5'(n + 1), cpuPkg::OP_ITYPE};
            progMem[n + 4] = {7'd0, 5'(n + 1), 5'd0, 3'b010, 5'(n * 4), cpuPkg::OP_STORE};
        end
        i = 8;
        while (i < progLen) begin
            kind = $urandom % 16;
            sel  = $urandom % 8;
            rd   = 5'($urandom % 8);
            r1   = 5'($urandom % 8);
            r2   = 5'($urandom % 8);
            imm  = 12'($urandom);
            if (kind < 5) begin
                progMem[i] = {1'b0, sel == 7, 5'd0, r2, r1, aluF3[sel], rd, cpuPkg::OP_RTYPE};
            end else if (kind < 9) begin
                progMem[i] = {imm, r1, aluF3[sel % 5], rd, cpuPkg::OP_ITYPE};
            end else if (kind < 13) begin
                imm = 12'(4 * (sel % 4)); // Only seeded words
                if (kind >= 11 && i + 1 < progLen) begin
                    progMem[i] = {imm[11:5], r2, 5'd0, 3'b010, imm[4:0], cpuPkg::OP_STORE};
                    i++; // LW of the same word right behind
                end
                progMem[i] = {imm, 5'd0, 3'b010, rd, cpuPkg::OP_LOAD};
            end else begin
                // Forward only, never past the first tail slot
                span       = (progLen - i > 8) ? 8 : progLen - i;
                bOff       = 13'(4 * (1 + $urandom % span));
                progMem[i] = {bOff[12], bOff[10:5], r2, r1,
                              (kind == 13) ? cpuPkg::F3_BEQ : cpuPkg::F3_BNE,
                              bOff[4:1], bOff[11], cpuPkg::OP_BRANCH};
            end
            i++;
        end
        for (int n = progLen; n < cpuPkg::IMEM_DEPTH; n++) begin
            progMem[n] = 32'h0000_0013; // ADDI x0, x0, 0
        end
    endtask

    // Reference model for one instruction, checked against the retirement report
    task automatic checkAndStep();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opB;
        logic [31:0] addr;
        logic [31:0] expData;
        logic [31:0] nextPc;
        logic        expEn;
        ins     = progMem[mPc[cpuPkg::IMEM_ADDR_W+1:2]];
        a       = mReg[ins[19:15]];
        b       = mReg[ins[24:20]];
        opB     = (ins[6:0] == cpuPkg::OP_ITYPE) ? {{20{ins[31]}}, ins[31:20]} : b;
        expEn   = 1'b0;
        expData = '0;
        nextPc  = mPc + 32'd4;
        addr    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]}; // Store address
        case (ins[6:0])
            cpuPkg::OP_RTYPE, cpuPkg::OP_ITYPE: begin
                expEn = 1'b1;
                case (ins[14:12])
                    cpuPkg::F3_ADD: expData = (ins[6:0] == cpuPkg::OP_RTYPE && ins[30]) ?
                                              a - opB : a + opB;
                    cpuPkg::F3_SLL: expData = a << opB[4:0];
                    cpuPkg::F3_SLT: expData = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
                    cpuPkg::F3_XOR: expData = a ^ opB;
                    cpuPkg::F3_SRL: expData = a >> opB[4:0];
                    cpuPkg::F3_OR:  expData = a | opB;
                    default:        expData = a & opB;
                endcase
            end
            cpuPkg::OP_LOAD: begin
                expEn   = 1'b1;
                addr    = a + {{20{ins[31]}}, ins[31:20]};
                expData = mMem[addr[cpuPkg::DMEM_ADDR_W+1:2]];
            end
            cpuPkg::OP_BRANCH: begin
                if ((ins[14:12] == cpuPkg::F3_BEQ && a == b) ||
                    (ins[14:12] == cpuPkg::F3_BNE && a != b)) begin
                    nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        expEn = expEn && (ins[11:7] != 5'd0); // x0 never reported
        compareValue("pc", mPc, pc);
        compareValue("inst", ins, inst);
        compareValue("wbEn", {31'd0, expEn}, {31'd0, wbEn});
        if (expEn) begin
            compareValue("wbReg", {27'd0, ins[11:7]}, {27'd0, wbReg});
            compareValue("wbData", expData, wbData);
            mReg[ins[11:7]] = expData;
        end
        if (ins[6:0] == cpuPkg::OP_STORE) begin
            mMem[addr[cpuPkg::DMEM_ADDR_W+1:2]] = b;
        end
        mPc = nextPc;
    endtask

    task automatic runProgram();
        logic inTail;
        int   steps;
        genProgram();
        @(posedge CLK);
        #2;
        rst = 1'b1;
        @(posedge CLK);
        #2;
        // Load under reset, then 10 more reset cycles
        for (int n = 0; n < cpuPkg::IMEM_DEPTH + 10; n++) begin
            imemWe    = (n < cpuPkg::IMEM_DEPTH);
            imemAddr  = n[cpuPkg::IMEM_ADDR_W-1:0];
            imemWdata = progMem[n % cpuPkg::IMEM_DEPTH];
            @(negedge CLK);
            compareValue("reset pc", '0, pc);
            compareValue("reset wbEn", '0, {31'd0, wbEn});
            @(posedge CLK);
            #2;
            cycleCount++;
        end
        imemWe = 1'b0;
        rst    = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mReg[r] = '0;
        end
        mPc    = '0;
        steps  = 0;
        inTail = 1'b0;
        while (!inTail) begin
            if (steps > cpuPkg::IMEM_DEPTH + 4) begin
                $display("Timeout: run %0d did not reach the no-op tail", runIdx);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            inTail = (mPc >= 32'(progLen * 4)); // Tail's first no-op is checked too
            @(negedge CLK);
            checkAndStep();
            @(posedge CLK);
            #2;
            steps++;
            cycleCount++;
        end
    endtask

    initial begin
        CLK        = 1'b0;
        rst        = 1'b1;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemWdata  = '0;
        cycleCount = 0;
        void'($urandom(32'hcc75));
        for (runIdx = 0; runIdx < 3; runIdx++) begin
            runProgram();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
hw/cpuPkg.sv
hw/alu.sv
hw/decoder.sv
hw/regFile.sv
hw/dataMem.sv
hw/instMem.sv
hw/singleCpu.sv
sim/tbSingleCpu.sv

// ==== Bender.yml ====
package:
  name: single_cpu

sources:
  - hw/cpuPkg.sv
  - hw/alu.sv
  - hw/decoder.sv
  - hw/regFile.sv
  - hw/dataMem.sv
  - hw/instMem.sv
  - hw/singleCpu.sv
  - target: test
    files:
      - sim/tbSingleCpu.sv
